// File: rtl/exec_pkg.sv
// Shared widths, micro-op bit positions, ALU and condition codes for the execute stage.
// Every execute module and the testbench import this package.
package exec_pkg;

    localparam int WORD_W   = 32;
    localparam int EFLAGS_W = 18;
    localparam int P_OP_W   = 18;

    typedef logic [WORD_W-1:0]   word_t;   // Operand, result, address or EIP
    typedef logic [EFLAGS_W-1:0] eflags_t;
    typedef logic [P_OP_W-1:0]   p_op_t;   // One-hot micro-op
    typedef logic [2:0]          alu_op_t;
    typedef logic [1:0]          opsize_t; // 0 byte, 1 word, 2 dword, 3 qword
    typedef logic [1:0]          cond_t;
    typedef logic [3:0]          ilen_t;

    // One-hot micro-op bit indices
    localparam int P_ADD       = 0;
    localparam int P_AND       = 1;
    localparam int P_OR        = 2;
    localparam int P_NOT       = 3;
    localparam int P_SAL       = 4;
    localparam int P_SAR       = 5;
    localparam int P_MOV       = 6;
    localparam int P_CMOVC     = 7;
    localparam int P_XCHG      = 8;
    localparam int P_MOVS      = 9;
    localparam int P_PUSH      = 10;
    localparam int P_POP       = 11;
    localparam int P_CALL_NEAR = 12;
    localparam int P_RET       = 13;
    localparam int P_JMP_NEAR  = 14;
    localparam int P_JCC       = 15;
    localparam int P_CLD       = 16;
    localparam int P_STD       = 17;

    // ALU functions
    localparam alu_op_t ALU_PASS = 3'd0; // res1 = op2
    localparam alu_op_t ALU_ADD  = 3'd1;
    localparam alu_op_t ALU_SUB  = 3'd2;
    localparam alu_op_t ALU_AND  = 3'd3;
    localparam alu_op_t ALU_OR   = 3'd4;
    localparam alu_op_t ALU_NOT  = 3'd5;
    localparam alu_op_t ALU_SHL  = 3'd6;
    localparam alu_op_t ALU_SAR  = 3'd7;

    // Branch and conditional-move conditions
    localparam cond_t CC_Z  = 2'd0;
    localparam cond_t CC_NZ = 2'd1;
    localparam cond_t CC_C  = 2'd2;
    localparam cond_t CC_NC = 2'd3;

    // EFLAGS bit positions
    localparam int FL_CF = 0;
    localparam int FL_PF = 1;
    localparam int FL_AF = 2;
    localparam int FL_ZF = 3;
    localparam int FL_SF = 4;
    localparam int FL_DF = 7;
    localparam int FL_OF = 8;

endpackage

// File: rtl/exec_control.sv
// Execute-stage control. Groups the one-hot micro-op into datapath selects,
// forms the internal and output valids and gates write-back and flag load.
module exec_control (
    input  exec_pkg::p_op_t   p_op,
    input  exec_pkg::cond_t   cond,
    input  exec_pkg::eflags_t flags,
    input  logic              valid_in,
    input  logic              latch_empty,
    input  logic [3:0]        res_ld,
    output logic              valid_int,
    output logic              valid_out,
    output logic [3:0]        res_wb,
    output logic              link_sel,
    output logic              push_sel,
    output logic              pop_sel,
    output logic              ret_sel,
    output logic              movs_sel,
    output logic              xchg_sel,
    output logic              jmp_sel,
    output logic              jcc_sel,
    output logic              call_sel,
    output logic              flags_ld,
    output logic              df_set,
    output logic              df_clr
);
    import exec_pkg::*;

    logic cmov_pass;
    logic skip;

    // Upstream latch empty means the inputs are stale
    assign valid_int = valid_in & ~latch_empty;

    // CMOVC moves on carry; the decoder may flip the sense with CC_NC
    assign cmov_pass = (cond == CC_NC) ? ~flags[FL_CF] : flags[FL_CF];
    assign skip      = p_op[P_CMOVC] & ~cmov_pass;
    assign valid_out = valid_int & ~skip;

    assign res_wb = res_ld & {4{valid_out}};

    // Stack pointer moves down for push and call
    assign push_sel = p_op[P_PUSH] | p_op[P_CALL_NEAR];
    assign pop_sel  = p_op[P_POP];
    assign ret_sel  = p_op[P_RET];
    assign movs_sel = p_op[P_MOVS];
    assign xchg_sel = p_op[P_XCHG];

    assign link_sel = p_op[P_CALL_NEAR]; // Return address goes out on res1
    assign call_sel = p_op[P_CALL_NEAR];
    assign jmp_sel  = p_op[P_JMP_NEAR];
    assign jcc_sel  = p_op[P_JCC];

    // fmask picks which bits actually change
    assign flags_ld = valid_out;
    assign df_set   = valid_out & p_op[P_STD];
    assign df_clr   = valid_out & p_op[P_CLD];

endmodule

// File: rtl/exec_alu.sv
// Integer ALU for the execute stage. Works at the width given by opsize and
// produces res1 plus a full flag image; a near call returns the fall-through EIP.
module exec_alu (
    input  exec_pkg::word_t   op1,
    input  exec_pkg::word_t   op2,
    input  exec_pkg::alu_op_t alu_op,
    input  exec_pkg::opsize_t opsize,
    input  logic              cf_in,
    input  logic              link_sel,
    input  exec_pkg::word_t   fallthru,
    output exec_pkg::word_t   res1,
    output exec_pkg::eflags_t flag_new
);
    import exec_pkg::*;

    logic [5:0]  width;     // Active width in bits
    word_t       mask;
    word_t       op1_sx;    // op1 sign-extended from the active width
    word_t       addend;
    logic [32:0] op1_ext;   // op1 with a zero bit on top
    logic [32:0] add_ext;
    logic        sub;
    logic [32:0] sum;
    logic [32:0] shl_ext;   // Bit at the width is the last bit shifted out
    logic [32:0] sar_ext;   // Bit 0 is the last bit shifted out
    logic [4:0]  shamt;
    logic        carry_w;   // Carry out of the active width
    logic        carry_msb; // Carry into the top bit of the active width
    word_t       result;
    logic        cf;
    logic        af;
    logic        of;

    always_comb begin
        case (opsize)
            2'd0: begin
                width  = 6'd8;
                mask   = 32'h0000_00ff;
                op1_sx = {{24{op1[7]}}, op1[7:0]};
            end
            2'd1: begin
                width  = 6'd16;
                mask   = 32'h0000_ffff;
                op1_sx = {{16{op1[15]}}, op1[15:0]};
            end
            default: begin // Qword runs at the 32-bit operand width
                width  = 6'd32;
                mask   = 32'hffff_ffff;
                op1_sx = op1;
            end
        endcase
    end

    // Subtract as op1 + ~op2 + 1
    assign sub       = (alu_op == ALU_SUB);
    assign addend    = sub ? ~op2 : op2;
    assign op1_ext   = {1'b0, op1};
    assign add_ext   = {1'b0, addend};
    assign sum       = op1_ext + add_ext + 33'(sub);
    assign carry_w   = sum[width] ^ op1_ext[width] ^ add_ext[width];
    assign carry_msb = sum[width-1] ^ op1[width-1] ^ addend[width-1];

    assign shamt   = op2[4:0];
    assign shl_ext = {1'b0, op1} << shamt;
    assign sar_ext = 33'($signed({op1_sx, 1'b0}) >>> shamt);

    always_comb begin
        cf = 1'b0;
        af = 1'b0;
        of = 1'b0;
        case (alu_op)
            ALU_ADD, ALU_SUB: begin
                result = sum[31:0];
                cf     = sub ? ~carry_w : carry_w; // Borrow on subtract
                af     = op1[4] ^ op2[4] ^ sum[4];
                of     = carry_w ^ carry_msb;
            end
            ALU_AND: result = op1 & op2;
            ALU_OR:  result = op1 | op2;
            ALU_NOT: result = ~op1;
            ALU_SHL: begin
                result = shl_ext[31:0];
                cf     = (shamt == 5'd0) ? cf_in : shl_ext[width];
                of     = result[width-1] ^ cf;
            end
            ALU_SAR: begin
                result = sar_ext[32:1];
                cf     = (shamt == 5'd0) ? cf_in : sar_ext[0];
            end
            default: result = op2; // ALU_PASS for MOV, CMOVC and XCHG
        endcase
    end

    always_comb begin
        flag_new        = '0;
        flag_new[FL_CF] = cf;
        flag_new[FL_PF] = ~^result[7:0]; // Even parity of the low byte
        flag_new[FL_AF] = af;
        flag_new[FL_ZF] = ((result & mask) == '0);
        flag_new[FL_SF] = result[width-1];
        flag_new[FL_OF] = of;
    end

    // Bits above ressize are ignored at write-back
    assign res1 = link_sel ? fallthru : result;

endmodule

// File: rtl/exec_flags.sv
// EFLAGS register. A load replaces only the bits selected by fmask;
// CLD and STD force the direction flag on the same edge.
module exec_flags (
    input  logic              clk,
    input  logic              reset,
    input  logic              flags_ld,
    input  exec_pkg::eflags_t fmask,
    input  exec_pkg::eflags_t flag_new,
    input  logic              df_set,
    input  logic              df_clr,
    output exec_pkg::eflags_t flags
);
    import exec_pkg::*;

    eflags_t flags_next;

    always_comb begin
        flags_next = flags;
        if (flags_ld) begin
            flags_next = (flags & ~fmask) | (flag_new & fmask);
        end
        if (df_set) begin
            flags_next[FL_DF] = 1'b1;
        end else if (df_clr) begin
            flags_next[FL_DF] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else begin
            flags <= flags_next;
        end
    end

endmodule

// File: rtl/exec_ptr_adjust.sv
// Pointer arithmetic for res2, res3 and res4. MOVS pointers move by the
// operand size in the DF direction; the stack pointer follows push, pop, call and return.
module exec_ptr_adjust (
    input  exec_pkg::word_t   op1,
    input  exec_pkg::word_t   op2,
    input  exec_pkg::word_t   op3,
    input  exec_pkg::word_t   op4,
    input  exec_pkg::opsize_t opsize,
    input  logic              df,
    input  logic              push_sel,
    input  logic              pop_sel,
    input  logic              ret_sel,
    input  logic              movs_sel,
    input  logic              xchg_sel,
    output exec_pkg::word_t   res2,
    output exec_pkg::word_t   res3,
    output exec_pkg::word_t   res4
);
    import exec_pkg::*;

    word_t step;      // 1, 2, 4 or 8
    word_t src_next;
    word_t dst_next;
    logic  ret_imm;

    assign step = word_t'(1) << opsize;

    // String pointers walk down when DF is set
    assign src_next = df ? (op2 - step) : (op2 + step);
    assign dst_next = df ? (op3 - step) : (op3 + step);

    always_comb begin
        if (xchg_sel) begin
            res2 = op1; // Swap value
        end else if (movs_sel) begin
            res2 = src_next;
        end else begin
            res2 = op2;
        end
    end

    assign res3 = movs_sel ? dst_next : op3;

    // RET imm16 releases the return address plus the immediate
    assign ret_imm = ret_sel & (op2 != '0);

    always_comb begin
        if (push_sel) begin
            res4 = op4 - step;
        end else if (ret_imm) begin
            res4 = op4 + 32'd4 + op2;
        end else if (pop_sel || ret_sel) begin
            res4 = op4 + step;
        end else begin
            res4 = op4;
        end
    end

endmodule

// File: rtl/exec_branch.sv
// Branch resolution for near jump, near call and conditional jump.
// Compares the outcome with the fetch prediction and gives the redirect address.
module exec_branch (
    input  exec_pkg::word_t   eip,
    input  exec_pkg::ilen_t   instr_len,
    input  exec_pkg::word_t   disp,
    input  exec_pkg::cond_t   cond,
    input  exec_pkg::eflags_t flags,
    input  logic              valid_int,
    input  logic              jmp_sel,
    input  logic              jcc_sel,
    input  logic              call_sel,
    input  exec_pkg::word_t   pred_target,
    input  logic              pred_taken,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_correct,
    output exec_pkg::word_t   br_fip,
    output exec_pkg::word_t   fallthru
);
    import exec_pkg::*;

    word_t target;
    logic  cond_true;

    assign fallthru = eip + word_t'(instr_len);
    assign target   = fallthru + disp; // Relative to the next instruction

    always_comb begin
        case (cond)
            CC_Z:    cond_true = flags[FL_ZF];
            CC_NZ:   cond_true = ~flags[FL_ZF];
            CC_C:    cond_true = flags[FL_CF];
            default: cond_true = ~flags[FL_CF];
        endcase
    end

    assign br_valid = valid_int & (jmp_sel | jcc_sel | call_sel);
    assign br_taken = jmp_sel | call_sel | (jcc_sel & cond_true);

    // Target only matters when the branch is taken
    assign br_correct = (br_taken == pred_taken) && (!br_taken || (target == pred_target));

    assign br_fip = br_taken ? target : fallthru;

endmodule

// File: rtl/execute_top.sv
// Execute stage of the pipelined x86 subset core. Takes one decoded micro-op
// per cycle and returns results, write-back strobes and branch resolution in the same cycle.
module execute_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    input  logic              latch_empty,
    input  exec_pkg::word_t   eip_in,
    input  exec_pkg::ilen_t   instr_len,
    input  exec_pkg::p_op_t   p_op,
    input  exec_pkg::alu_op_t alu_op,
    input  exec_pkg::opsize_t opsize,
    input  exec_pkg::cond_t   cond,
    input  exec_pkg::eflags_t fmask,
    input  exec_pkg::word_t   op1,
    input  exec_pkg::word_t   op2,
    input  exec_pkg::word_t   op3,
    input  exec_pkg::word_t   op4,
    input  exec_pkg::word_t   dest1,
    input  exec_pkg::word_t   dest2,
    input  exec_pkg::word_t   dest3,
    input  exec_pkg::word_t   dest4,
    input  logic [3:0]        res_ld,
    input  logic [3:0]        res_is_reg,
    input  logic [3:0]        res_is_mem,
    input  exec_pkg::word_t   pred_target,
    input  logic              pred_taken,
    output logic              valid_out,
    output exec_pkg::word_t   eip_out,
    output exec_pkg::word_t   res1,
    output exec_pkg::word_t   res2,
    output exec_pkg::word_t   res3,
    output exec_pkg::word_t   res4,
    output exec_pkg::word_t   res1_dest,
    output exec_pkg::word_t   res2_dest,
    output exec_pkg::word_t   res3_dest,
    output exec_pkg::word_t   res4_dest,
    output logic [3:0]        res_wb,
    output logic [3:0]        res_is_reg_out,
    output logic [3:0]        res_is_mem_out,
    output exec_pkg::opsize_t ressize,
    output exec_pkg::eflags_t eflags,
    output logic              br_valid,
    output logic              br_taken,
    output logic              br_correct,
    output exec_pkg::word_t   br_fip
);
    import exec_pkg::*;

    logic    valid_int;
    logic    link_sel;
    logic    push_sel;
    logic    pop_sel;
    logic    ret_sel;
    logic    movs_sel;
    logic    xchg_sel;
    logic    jmp_sel;
    logic    jcc_sel;
    logic    call_sel;
    logic    flags_ld;
    logic    df_set;
    logic    df_clr;
    word_t   fallthru;  // Return address for near call
    eflags_t flag_new;

    exec_control u_control (
        .p_op(p_op), .cond(cond), .flags(eflags), .valid_in(valid_in),
        .latch_empty(latch_empty), .res_ld(res_ld), .valid_int(valid_int),
        .valid_out(valid_out), .res_wb(res_wb), .link_sel(link_sel),
        .push_sel(push_sel), .pop_sel(pop_sel), .ret_sel(ret_sel),
        .movs_sel(movs_sel), .xchg_sel(xchg_sel), .jmp_sel(jmp_sel),
        .jcc_sel(jcc_sel), .call_sel(call_sel), .flags_ld(flags_ld),
        .df_set(df_set), .df_clr(df_clr)
    );

    exec_alu u_alu (
        .op1(op1), .op2(op2), .alu_op(alu_op), .opsize(opsize),
        .cf_in(eflags[FL_CF]), .link_sel(link_sel), .fallthru(fallthru),
        .res1(res1), .flag_new(flag_new)
    );

    exec_flags u_flags (
        .clk(clk), .reset(reset), .flags_ld(flags_ld), .fmask(fmask),
        .flag_new(flag_new), .df_set(df_set), .df_clr(df_clr), .flags(eflags)
    );

    exec_ptr_adjust u_ptr_adjust (
        .op1(op1), .op2(op2), .op3(op3), .op4(op4), .opsize(opsize),
        .df(eflags[FL_DF]), .push_sel(push_sel), .pop_sel(pop_sel),
        .ret_sel(ret_sel), .movs_sel(movs_sel), .xchg_sel(xchg_sel),
        .res2(res2), .res3(res3), .res4(res4)
    );

    // op2 carries the relative displacement for branches
    exec_branch u_branch (
        .eip(eip_in), .instr_len(instr_len), .disp(op2), .cond(cond),
        .flags(eflags), .valid_int(valid_int), .jmp_sel(jmp_sel),
        .jcc_sel(jcc_sel), .call_sel(call_sel), .pred_target(pred_target),
        .pred_taken(pred_taken), .br_valid(br_valid), .br_taken(br_taken),
        .br_correct(br_correct), .br_fip(br_fip), .fallthru(fallthru)
    );

    assign eip_out        = eip_in;
    assign res1_dest      = dest1;
    assign res2_dest      = dest2;
    assign res3_dest      = dest3;
    assign res4_dest      = dest4;
    assign res_is_reg_out = res_is_reg;
    assign res_is_mem_out = res_is_mem;
    assign ressize        = opsize;

endmodule

// File: dv/execute_tb.sv
// Directed testbench for the execute stage. Drives one micro-op per falling edge,
// checks the same-cycle results and the EFLAGS update after the next rising edge.
module execute_tb;
    import exec_pkg::*;

    localparam int      MAX_CYCLES = 400;
    localparam eflags_t ARITH_MASK = 18'h0011f; // CF PF AF ZF SF OF
    localparam eflags_t LOGIC_MASK = 18'h0011b; // AF untouched
    localparam eflags_t ZC_MASK    = 18'h00009;

    logic       clk, reset, valid_in, latch_empty, pred_taken;
    word_t      eip_in, op1, op2, op3, op4, pred_target;
    word_t      dest1, dest2, dest3, dest4;
    ilen_t      instr_len;
    p_op_t      p_op;
    alu_op_t    alu_op;
    opsize_t    opsize, ressize;
    cond_t      cond;
    eflags_t    fmask, eflags;
    logic [3:0] res_ld, res_is_reg, res_is_mem, res_wb, res_is_reg_out, res_is_mem_out;
    logic       valid_out, br_valid, br_taken, br_correct;
    word_t      eip_out, res1, res2, res3, res4, br_fip;
    word_t      res1_dest, res2_dest, res3_dest, res4_dest;
    integer     seed = 32'hce23;
    int         errors = 0;
    int         cycles = 0;

    execute_top UUT (
        .clk(clk), .reset(reset), .valid_in(valid_in), .latch_empty(latch_empty),
        .eip_in(eip_in), .instr_len(instr_len), .p_op(p_op), .alu_op(alu_op),
        .opsize(opsize), .cond(cond), .fmask(fmask), .op1(op1), .op2(op2), .op3(op3),
        .op4(op4), .dest1(dest1), .dest2(dest2), .dest3(dest3), .dest4(dest4),
        .res_ld(res_ld), .res_is_reg(res_is_reg), .res_is_mem(res_is_mem),
        .pred_target(pred_target), .pred_taken(pred_taken), .valid_out(valid_out),
        .eip_out(eip_out), .res1(res1), .res2(res2), .res3(res3), .res4(res4),
        .res1_dest(res1_dest), .res2_dest(res2_dest), .res3_dest(res3_dest),
        .res4_dest(res4_dest), .res_wb(res_wb), .res_is_reg_out(res_is_reg_out),
        .res_is_mem_out(res_is_mem_out), .ressize(ressize), .eflags(eflags),
        .br_valid(br_valid), .br_taken(br_taken), .br_correct(br_correct), .br_fip(br_fip)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input string what, input eflags_t got, input eflags_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic word_t mask_of(input opsize_t sz);
        case (sz)
            2'd0: return 32'h0000_00ff;
            2'd1: return 32'h0000_ffff;
            default: return 32'hffff_ffff; // Qword runs at 32 bits
        endcase
    endfunction

    // Expected result and flags at the operand width
    task automatic alu_model(input alu_op_t f, input word_t a, input word_t b,
                             input opsize_t sz, output word_t r, output eflags_t fl);
        int          w;
        int          s;
        word_t       m;
        word_t       sx;
        logic [32:0] wide;
        logic        cf;
        logic        af;
        logic        of;
        w  = (sz == 2'd0) ? 8 : (sz == 2'd1) ? 16 : 32;
        m  = mask_of(sz);
        s  = b[4:0];
        sx = (a & m) | (a[w-1] ? ~m : 32'h0);
        cf = 1'b0;
        af = 1'b0;
        of = 1'b0;
        case (f)
            ALU_ADD: begin
                r    = a + b;
                wide = 33'(a & m) + 33'(b & m);
                cf   = wide[w];
                of   = (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]);
                af   = a[4] ^ b[4] ^ r[4];
            end
            ALU_SUB: begin
                r  = a - b;
                cf = (a & m) < (b & m); // Borrow
                of = (a[w-1] != b[w-1]) && (r[w-1] != a[w-1]);
                af = a[4] ^ b[4] ^ r[4];
            end
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_NOT: r = ~a;
            ALU_SHL: begin
                r  = a << s;
                cf = a[w-s]; // Last bit out of the top
                of = r[w-1] ^ cf;
            end
            ALU_SAR: begin
                r  = word_t'($signed(sx) >>> s);
                cf = a[s-1];
            end
            default: r = b;
        endcase
        fl        = '0;
        fl[FL_CF] = cf;
        fl[FL_PF] = ~^r[7:0];
        fl[FL_AF] = af;
        fl[FL_ZF] = ((r & m) == 32'h0);
        fl[FL_SF] = r[w-1];
        fl[FL_OF] = of;
    endtask

    // Caller waits for the falling edge first; outputs settle 1 unit later
    task automatic drive(input int bit_idx, input alu_op_t f, input opsize_t sz,
                         input eflags_t m, input word_t a, input word_t b);
        p_op   = p_op_t'(1) << bit_idx;
        alu_op = f;
        opsize = sz;
        fmask  = m;
        op1    = a;
        op2    = b;
        #1;
    endtask

    task automatic expect_flags(input eflags_t exp);
        @(posedge clk);
        #1;
        check_flags("eflags", eflags, exp);
    endtask

    // Byte add ff+01 sets ZF and CF, 01+01 clears both
    task automatic set_zc(input logic v);
        @(negedge clk);
        drive(P_ADD, ALU_ADD, 2'd0, ZC_MASK, v ? 32'hff : 32'h01, 32'h01);
        expect_flags((eflags & ~ZC_MASK) | (v ? ZC_MASK : 18'h0));
    endtask

    task automatic alu_ops;
        alu_op_t ops[7]   = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_SHL, ALU_SAR};
        int      bits[7]  = '{P_ADD, P_ADD, P_AND, P_OR, P_NOT, P_SAL, P_SAR};
        eflags_t masks[7] = '{ARITH_MASK, ARITH_MASK, LOGIC_MASK, LOGIC_MASK, 18'h0,
                              LOGIC_MASK, LOGIC_MASK};
        word_t   a, b, r, m;
        eflags_t fl, prev;
        int      w;
        for (int rep = 0; rep < 2; rep++) begin
            for (int sz = 0; sz < 4; sz++) begin
                for (int k = 0; k < 7; k++) begin
                    w = (sz == 0) ? 8 : (sz == 1) ? 16 : 32;
                    m = mask_of(opsize_t'(sz));
                    a = $random(seed);
                    b = $random(seed);
                    if (k >= 5) begin
                        b = b % word_t'(w - 1) + 32'd1; // Shift counts 1 to w-1
                    end
                    alu_model(ops[k], a, b, opsize_t'(sz), r, fl);
                    @(negedge clk);
                    drive(bits[k], ops[k], opsize_t'(sz), masks[k], a, b);
                    check_word("res1", res1 & m, r & m);
                    check_bit("valid_out", valid_out, 1'b1);
                    prev = eflags;
                    expect_flags((prev & ~masks[k]) | (fl & masks[k]));
                end
            end
        end
    endtask

    task automatic stack_ops;
        word_t sp;
        sp = $random(seed) & 32'hffff_fff0;
        @(negedge clk);
        op4 = sp;
        drive(P_PUSH, ALU_PASS, 2'd2, 18'h0, 32'h0, 32'h0);
        check_word("res4 push", res4, sp - 32'd4);
        check_word("res1_dest", res1_dest, dest1);
        check_word("res2_dest", res2_dest, dest2);
        check_word("res3_dest", res3_dest, dest3);
        check_word("res4_dest", res4_dest, dest4);
        check_word("res_is_reg_out", word_t'(res_is_reg_out), 32'h3);
        check_word("res_is_mem_out", word_t'(res_is_mem_out), 32'h4);
        @(negedge clk);
        drive(P_POP, ALU_PASS, 2'd1, 18'h0, 32'h0, 32'h0);
        check_word("res4 pop", res4, sp + 32'd2);
        check_word("ressize", word_t'(ressize), 32'd1);
        @(negedge clk);
        eip_in    = 32'h0000_4000;
        instr_len = 4'd5;
        drive(P_CALL_NEAR, ALU_PASS, 2'd2, 18'h0, 32'h0, 32'h0000_0100);
        check_word("res4 call", res4, sp - 32'd4);
        check_word("res1 call", res1, 32'h0000_4005); // Fall-through address
        check_word("eip_out", eip_out, 32'h0000_4000);
        @(negedge clk);
        drive(P_RET, ALU_PASS, 2'd3, 18'h0, 32'h0, 32'h0);
        check_word("res4 ret", res4, sp + 32'd8);
        @(negedge clk);
        drive(P_RET, ALU_PASS, 2'd1, 18'h0, 32'h0, 32'h0000_000c);
        check_word("res4 ret imm", res4, sp + 32'd4 + 32'h0000_000c);
    endtask

    task automatic movs_steps;
        word_t src, dst;
        src = $random(seed);
        dst = $random(seed);
        @(negedge clk);
        drive(P_STD, ALU_PASS, 2'd2, 18'h0, 32'h0, 32'h0);
        expect_flags(eflags | (eflags_t'(1) << FL_DF));
        @(negedge clk);
        op3 = dst;
        drive(P_MOVS, ALU_PASS, 2'd2, 18'h0, 32'h0, src);
        check_word("res2 movs down", res2, src - 32'd4);
        check_word("res3 movs down", res3, dst - 32'd4);
        @(negedge clk);
        drive(P_CLD, ALU_PASS, 2'd2, 18'h0, 32'h0, 32'h0);
        expect_flags(eflags & ~(eflags_t'(1) << FL_DF));
        @(negedge clk);
        drive(P_MOVS, ALU_PASS, 2'd1, 18'h0, 32'h0, src);
        check_word("res2 movs up", res2, src + 32'd2);
        check_word("res3 movs up", res3, dst + 32'd2);
    endtask

    task automatic cmov_and_xchg;
        word_t a, b;
        a = $random(seed);
        b = $random(seed);
        set_zc(1'b0);
        @(negedge clk);
        cond   = CC_C;
        res_ld = 4'b0101;
        drive(P_CMOVC, ALU_PASS, 2'd2, 18'h0, a, b);
        check_bit("valid_out cmovc no carry", valid_out, 1'b0);
        check_word("res_wb cmovc no carry", word_t'(res_wb), 32'h0);
        set_zc(1'b1);
        @(negedge clk);
        drive(P_CMOVC, ALU_PASS, 2'd2, 18'h0, a, b);
        check_bit("valid_out cmovc carry", valid_out, 1'b1);
        check_word("res_wb cmovc carry", word_t'(res_wb), 32'h5);
        check_word("res1 cmovc", res1, b);
        @(negedge clk);
        drive(P_XCHG, ALU_PASS, 2'd2, 18'h0, a, b);
        check_word("res2 xchg", res2, a);
        check_word("res1 xchg", res1, b);
        check_word("res_wb xchg", word_t'(res_wb), 32'h5);
    endtask

    // Taken comes from the caller; tgt_ok picks a right or wrong predicted target
    task automatic run_branch(input int bit_idx, input cond_t cc, input logic taken,
                              input logic pt, input logic tgt_ok);
        word_t disp;
        word_t fall;
        word_t tgt;
        disp = $random(seed);
        @(negedge clk);
        eip_in      = $random(seed);
        instr_len   = 4'd6;
        cond        = cc;
        fall        = eip_in + 32'd6;
        tgt         = fall + disp;
        pred_taken  = pt;
        pred_target = tgt_ok ? tgt : tgt + 32'd4;
        drive(bit_idx, ALU_PASS, 2'd2, 18'h0, 32'h0, disp);
        check_bit("br_valid", br_valid, 1'b1);
        check_bit("br_taken", br_taken, taken);
        check_bit("br_correct", br_correct, (taken == pt) && (!taken || tgt_ok));
        check_word("br_fip", br_fip, taken ? tgt : fall);
    endtask

    task automatic branch_checks;
        logic taken;
        run_branch(P_JMP_NEAR, CC_Z, 1'b1, 1'b1, 1'b1);
        run_branch(P_JMP_NEAR, CC_Z, 1'b1, 1'b1, 1'b0);
        run_branch(P_CALL_NEAR, CC_NC, 1'b1, 1'b1, 1'b1);
        run_branch(P_CALL_NEAR, CC_NC, 1'b1, 1'b0, 1'b1);
        for (int v = 0; v < 2; v++) begin
            set_zc(v == 1); // ZF and CF both equal v
            for (int cc = 0; cc < 4; cc++) begin
                taken = (cc == CC_Z || cc == CC_C) ? (v == 1) : (v == 0);
                run_branch(P_JCC, cond_t'(cc), taken, taken, 1'b1);
                run_branch(P_JCC, cond_t'(cc), taken, taken, 1'b0);
                run_branch(P_JCC, cond_t'(cc), taken, !taken, 1'b1);
            end
        end
    endtask

    task automatic backpressure;
        set_zc(1'b1); // A leaked byte add 01+01 would clear ZF and CF
        @(negedge clk);
        latch_empty = 1'b1;
        res_ld      = 4'b1111;
        drive(P_ADD, ALU_ADD, 2'd0, ARITH_MASK, 32'h01, 32'h01);
        check_bit("valid_out stalled", valid_out, 1'b0);
        check_word("res_wb stalled", word_t'(res_wb), 32'h0);
        expect_flags(eflags);
        @(negedge clk);
        drive(P_JMP_NEAR, ALU_PASS, 2'd2, 18'h0, 32'h0, 32'h10);
        check_bit("br_valid stalled", br_valid, 1'b0);
        @(negedge clk);
        latch_empty = 1'b0;
        valid_in    = 1'b0;
        drive(P_ADD, ALU_ADD, 2'd0, ARITH_MASK, 32'h01, 32'h01);
        check_bit("valid_out idle", valid_out, 1'b0);
        check_word("res_wb idle", word_t'(res_wb), 32'h0);
        expect_flags(eflags);
    endtask

    initial begin
        reset       = 1'b1;
        valid_in    = 1'b0;
        latch_empty = 1'b0;
        pred_taken  = 1'b0;
        instr_len   = 4'd0;
        p_op        = '0;
        alu_op      = ALU_PASS;
        opsize      = 2'd0;
        cond        = CC_Z;
        fmask       = '0;
        res_ld      = 4'b0001;
        res_is_reg  = 4'b0011;
        res_is_mem  = 4'b0100;
        {op1, op2, op3, op4, eip_in, pred_target} = '0;
        {dest1, dest2, dest3, dest4} = {32'd1, 32'd2, 32'd3, 32'd4};
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        valid_in = 1'b1;
        #1;
        check_flags("eflags after reset", eflags, '0);
        alu_ops();
        stack_ops();
        movs_steps();
        cmov_and_xchg();
        branch_checks();
        backpressure();
        $display("Run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
rtl/exec_pkg.sv
rtl/exec_control.sv
rtl/exec_alu.sv
rtl/exec_flags.sv
rtl/exec_ptr_adjust.sv
rtl/exec_branch.sv
rtl/execute_top.sv
dv/execute_tb.sv
